/* Makefile */
TOP = ex_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* hw/core_pkg.sv */
`include "mt_config.svh"

package core_pkg;

	// one extra code beyond the last thread marks an idle lane
	typedef logic [$clog2(`MT_NUM_THREADS + 1)-1:0] thread_id_t;

	localparam thread_id_t TID_IDLE = thread_id_t'(`MT_NUM_THREADS);

	typedef struct packed {
		logic                valid;
		logic [`MT_XLEN-1:0] pc;
		isa_pkg::instr_u     ins;
		logic [`MT_XLEN-1:0] op1; // value of rs1
		logic [`MT_XLEN-1:0] op2; // value of rs2
	} decode_bundle_t;

	typedef decode_bundle_t queue_entry_t; // stored as presented

	typedef struct packed {
		logic                wen;
		logic [4:0]          rd;
		logic [`MT_XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic                en;
		logic [`MT_XLEN-1:0] addr;
	} jump_t;

	typedef struct packed {
		queue_entry_t entry;
		thread_id_t   tid;
	} lane_issue_t;

	typedef struct packed {
		logic       valid;
		thread_id_t tid;
		wb_t        wb;
		jump_t      jump;
	} lane_result_t;

endpackage

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module ex_stage (
	input  logic                     clk,
	input  logic                     rst,
	input  core_pkg::decode_bundle_t decode       [`MT_NUM_THREADS],
	input  core_pkg::thread_id_t     dispatch_sel [`MT_NUM_LANES],
	output core_pkg::wb_t            wb           [`MT_NUM_THREADS],
	output core_pkg::jump_t          jump         [`MT_NUM_THREADS]
);

	core_pkg::queue_entry_t     heads   [`MT_NUM_THREADS];
	logic [`MT_NUM_THREADS-1:0] empty;
	logic [`MT_NUM_THREADS-1:0] dispatched;
	core_pkg::lane_issue_t      issue   [`MT_NUM_LANES];
	core_pkg::lane_result_t     results [`MT_NUM_LANES];

	for (genvar t = 0; t < `MT_NUM_THREADS; t++) begin : g_queue
		issue_queue i_queue (
			.clk        (clk),
			.rst        (rst),
			.decode     (decode[t]),
			.dispatched (dispatched[t]),
			.wb         (wb[t]),      // registered result feeds forwarding
			.jump_en    (jump[t].en), // and the flush
			.head       (heads[t]),
			.empty      (empty[t])
		);
	end

	lane_select i_select (
		.decode       (decode),
		.heads        (heads),
		.empty        (empty),
		.dispatch_sel (dispatch_sel),
		.issue        (issue),
		.dispatched   (dispatched)
	);

	for (genvar l = 0; l < `MT_NUM_LANES; l++) begin : g_lane
		exec_lane i_lane (
			.issue  (issue[l]),
			.result (results[l])
		);
	end

	result_route i_route (
		.clk     (clk),
		.rst     (rst),
		.results (results),
		.wb      (wb),
		.jump    (jump)
	);

endmodule

/* hw/exec_lane.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module exec_lane (
	input  core_pkg::lane_issue_t  issue,
	output core_pkg::lane_result_t result
);

	isa_pkg::instr_u     ins;
	isa_pkg::lane_op_e   op;
	logic [`MT_XLEN-1:0] op1;
	logic [`MT_XLEN-1:0] op2;
	logic [`MT_XLEN-1:0] b_imm;
	logic [`MT_XLEN-1:0] alu_out;
	logic                taken;
	logic                is_branch;

	assign ins   = issue.entry.ins;
	assign op1   = issue.entry.op1;
	assign op2   = issue.entry.op2;
	assign b_imm = {{(`MT_XLEN - 12){ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5,
		ins.b.imm4_1, 1'b0};

	always_comb begin
		op = isa_pkg::OP_NONE;
		case (ins.r.opcode)
			isa_pkg::OPC_OP: begin
				case ({ins.r.funct7, ins.r.funct3})
					{isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB}: op = isa_pkg::OP_ADD;
					{isa_pkg::F7_SUB, isa_pkg::F3_ADD_SUB}:  op = isa_pkg::OP_SUB;
					{isa_pkg::F7_BASE, isa_pkg::F3_AND}:     op = isa_pkg::OP_AND;
					{isa_pkg::F7_BASE, isa_pkg::F3_OR}:      op = isa_pkg::OP_OR;
					{isa_pkg::F7_BASE, isa_pkg::F3_XOR}:     op = isa_pkg::OP_XOR;
					default:                                 op = isa_pkg::OP_NONE;
				endcase
			end
			isa_pkg::OPC_BRANCH: begin
				if (ins.b.funct3 == isa_pkg::F3_BEQ) begin
					op = isa_pkg::OP_BEQ;
				end else if (ins.b.funct3 == isa_pkg::F3_BNE) begin
					op = isa_pkg::OP_BNE;
				end
			end
			default: op = isa_pkg::OP_NONE; // unsupported class
		endcase
	end

	always_comb begin
		alu_out = '0;
		taken   = 1'b0;
		case (op)
			isa_pkg::OP_ADD: alu_out = op1 + op2;
			isa_pkg::OP_SUB: alu_out = op1 - op2;
			isa_pkg::OP_AND: alu_out = op1 & op2;
			isa_pkg::OP_OR:  alu_out = op1 | op2;
			isa_pkg::OP_XOR: alu_out = op1 ^ op2;
			isa_pkg::OP_BEQ: taken = (op1 == op2);
			isa_pkg::OP_BNE: taken = (op1 != op2);
			default:         alu_out = '0;
		endcase
	end

	assign is_branch = (op == isa_pkg::OP_BEQ) || (op == isa_pkg::OP_BNE);

	always_comb begin
		result           = '0;
		result.valid     = issue.entry.valid && (op != isa_pkg::OP_NONE);
		result.tid       = issue.tid;
		result.wb.wen    = result.valid && !is_branch && (ins.r.rd != 5'd0); // x0 stays zero
		result.wb.rd     = ins.r.rd;
		result.wb.data   = alu_out;
		result.jump.en   = result.valid && taken;
		result.jump.addr = issue.entry.pc + b_imm;
	end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11; // sits where rd lives in r view
		logic [6:0] opcode;
	} b_fmt_t;

	// one word, two decodings
	typedef union packed {
		r_fmt_t r;
		b_fmt_t b;
	} instr_u;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000; // also the alt bit of sra

	typedef enum logic [2:0] {
		OP_NONE,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_BEQ,
		OP_BNE
	} lane_op_e;

endpackage

/* hw/issue_queue.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module issue_queue (
	input  logic                     clk,
	input  logic                     rst,
	input  core_pkg::decode_bundle_t decode,
	input  logic                     dispatched,
	input  core_pkg::wb_t            wb,
	input  logic                     jump_en,
	output core_pkg::queue_entry_t   head,
	output logic                     empty
);

	core_pkg::queue_entry_t q      [`MT_QUEUE_DEPTH];
	core_pkg::queue_entry_t fq     [`MT_QUEUE_DEPTH]; // q with writeback applied
	core_pkg::queue_entry_t sh     [`MT_QUEUE_DEPTH]; // after head removal
	core_pkg::queue_entry_t q_next [`MT_QUEUE_DEPTH];
	core_pkg::queue_entry_t incoming;
	logic                   dup;
	logic                   bypass;
	logic                   placed;

	function automatic core_pkg::queue_entry_t forward(
		input core_pkg::queue_entry_t e,
		input core_pkg::wb_t          w
	);
		core_pkg::queue_entry_t f;
		f = e;
		if (w.wen && w.rd != 5'd0) begin
			if (e.ins.r.rs1 == w.rd) begin
				f.op1 = w.data;
			end
			if (e.ins.r.rs2 == w.rd) begin
				f.op2 = w.data;
			end
		end
		return f;
	endfunction

	always_comb begin
		for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
			fq[i] = forward(q[i], wb);
		end
		incoming = forward(decode, wb);

		// decode repeats a pc until it moves on
		dup = 1'b0;
		for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
			if (q[i].valid && q[i].pc == decode.pc) begin
				dup = 1'b1;
			end
		end
		bypass = dispatched && !q[0].valid; // lane took decode directly

		for (int i = 0; i < `MT_QUEUE_DEPTH - 1; i++) begin
			sh[i] = dispatched ? fq[i + 1] : fq[i];
		end
		sh[`MT_QUEUE_DEPTH - 1] = fq[`MT_QUEUE_DEPTH - 1];
		if (dispatched) begin
			sh[`MT_QUEUE_DEPTH - 1].valid = 1'b0;
		end

		// valid entries stay packed at the front, so the first hole is the tail
		q_next = sh;
		placed = 1'b0;
		for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
			if (!placed && !sh[i].valid && decode.valid && !dup && !bypass) begin
				q_next[i] = incoming;
				placed = 1'b1;
			end
		end

		if (jump_en) begin // taken branch, drop wrong path
			for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
				q_next[i].valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
				q[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `MT_QUEUE_DEPTH; i++) begin
				q[i] <= q_next[i];
			end
		end
	end

	assign head  = fq[0]; // same-cycle writeback reaches the lane too
	assign empty = !q[0].valid;

endmodule

/* hw/lane_select.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module lane_select (
	input  core_pkg::decode_bundle_t    decode       [`MT_NUM_THREADS],
	input  core_pkg::queue_entry_t      heads        [`MT_NUM_THREADS],
	input  logic [`MT_NUM_THREADS-1:0]  empty,
	input  core_pkg::thread_id_t        dispatch_sel [`MT_NUM_LANES],
	output core_pkg::lane_issue_t       issue        [`MT_NUM_LANES],
	output logic [`MT_NUM_THREADS-1:0]  dispatched
);

	logic [$clog2(`MT_NUM_THREADS)-1:0] slot [`MT_NUM_LANES];

	always_comb begin
		for (int l = 0; l < `MT_NUM_LANES; l++) begin
			slot[l] = dispatch_sel[l][$clog2(`MT_NUM_THREADS)-1:0];
		end
	end

	always_comb begin
		dispatched = '0;
		for (int l = 0; l < `MT_NUM_LANES; l++) begin
			issue[l].entry = '0; // idle lane issues nothing valid
			issue[l].tid   = dispatch_sel[l];
			if (dispatch_sel[l] != core_pkg::TID_IDLE) begin
				if (empty[slot[l]]) begin
					issue[l].entry = decode[slot[l]]; // bypass
				end else begin
					issue[l].entry = heads[slot[l]];
				end
				dispatched[slot[l]] = 1'b1;
			end
		end
	end

endmodule

/* hw/mt_config.svh */
`ifndef MT_CONFIG_SVH
`define MT_CONFIG_SVH

// hardware threads sharing the stage
`define MT_NUM_THREADS 4

`define MT_NUM_LANES 3   // alus
`define MT_QUEUE_DEPTH 3 // entries per thread

// data and pc width
`define MT_XLEN 32

`endif

/* hw/result_route.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module result_route (
	input  logic                   clk,
	input  logic                   rst,
	input  core_pkg::lane_result_t results [`MT_NUM_LANES],
	output core_pkg::wb_t          wb      [`MT_NUM_THREADS],
	output core_pkg::jump_t        jump    [`MT_NUM_THREADS]
);

	logic [$clog2(`MT_NUM_THREADS)-1:0] slot [`MT_NUM_LANES];

	always_comb begin
		for (int l = 0; l < `MT_NUM_LANES; l++) begin
			slot[l] = results[l].tid[$clog2(`MT_NUM_THREADS)-1:0];
		end
	end

	// one register stage, every output lives for a single cycle
	always_ff @(posedge clk) begin
		for (int t = 0; t < `MT_NUM_THREADS; t++) begin
			wb[t]   <= '0;
			jump[t] <= '0;
		end
		if (rst) begin
			for (int l = 0; l < `MT_NUM_LANES; l++) begin
				if (results[l].valid) begin // idle lanes never valid
					wb[slot[l]]   <= results[l].wb;
					jump[slot[l]] <= results[l].jump;
				end
			end
		end
	end

endmodule

/* project.f */
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/issue_queue.sv
hw/lane_select.sv
hw/exec_lane.sv
hw/result_route.sv
hw/ex_stage.sv
tests/ex_stage_checker.sv
tests/ex_stage_tb.sv

/* tests/ex_stage_checker.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module ex_stage_checker (
	input logic                 clk,
	input logic                 rst,
	input core_pkg::wb_t        wb   [`MT_NUM_THREADS],
	input core_pkg::jump_t      jump [`MT_NUM_THREADS]
);

	for (genvar t = 0; t < `MT_NUM_THREADS; t++) begin : g_thread
		// x0 is never a writeback target
		assert property (@(posedge clk) disable iff (!rst)
			wb[t].wen |-> wb[t].rd != 5'd0)
			else $error("thread %0d wrote back to x0", t);

		// a branch never writes a register
		assert property (@(posedge clk) disable iff (!rst)
			!(wb[t].wen && jump[t].en))
			else $error("thread %0d has writeback and jump in the same cycle", t);

		assert property (@(posedge clk)
			!rst |=> !wb[t].wen && !jump[t].en) // cleared by reset
			else $error("thread %0d output active right after reset", t);
	end

endmodule

bind ex_stage ex_stage_checker i_checker (
	.clk  (clk),
	.rst  (rst),
	.wb   (wb),
	.jump (jump)
);

/* tests/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "mt_config.svh"

module ex_stage_tb;

	localparam int CYCLE_LIMIT = 400; // stimulus needs about 45 cycles

	logic clk = 1'b0;
	logic rst;
	core_pkg::decode_bundle_t decode       [`MT_NUM_THREADS];
	core_pkg::thread_id_t     dispatch_sel [`MT_NUM_LANES];
	core_pkg::wb_t            wb           [`MT_NUM_THREADS];
	core_pkg::jump_t          jump         [`MT_NUM_THREADS];

	core_pkg::wb_t   exp_wb   [`MT_NUM_THREADS]; // for the cycle being driven
	core_pkg::jump_t exp_jump [`MT_NUM_THREADS];
	core_pkg::wb_t   due_wb   [`MT_NUM_THREADS]; // for the registered outputs
	core_pkg::jump_t due_jump [`MT_NUM_THREADS];
	logic            due_on = 1'b0;
	int              cycles = 0;
	logic [31:0]     a;
	logic [31:0]     b;
	logic [31:0]     c;

	ex_stage i_dut (
		.clk          (clk),
		.rst          (rst),
		.decode       (decode),
		.dispatch_sel (dispatch_sel),
		.wb           (wb),
		.jump         (jump)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		due_wb   <= exp_wb;
		due_jump <= exp_jump;
		due_on   <= 1'b1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_on_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
		$display("** FAIL **");
		$fatal(1, "output mismatch");
	endtask

	// outputs are stable around the falling edge
	for (genvar t = 0; t < `MT_NUM_THREADS; t++) begin : g_check
		assert property (@(negedge clk) due_on |-> wb[t].wen == due_wb[t].wen)
			else stop_on_mismatch($sformatf("wb[%0d].wen", t), 64'(due_wb[t].wen),
				64'(wb[t].wen));
		assert property (@(negedge clk) due_on && due_wb[t].wen |-> wb[t].rd == due_wb[t].rd)
			else stop_on_mismatch($sformatf("wb[%0d].rd", t), 64'(due_wb[t].rd),
				64'(wb[t].rd));
		assert property (@(negedge clk)
			due_on && due_wb[t].wen |-> wb[t].data == due_wb[t].data)
			else stop_on_mismatch($sformatf("wb[%0d].data", t), 64'(due_wb[t].data),
				64'(wb[t].data));
		assert property (@(negedge clk) due_on |-> jump[t].en == due_jump[t].en)
			else stop_on_mismatch($sformatf("jump[%0d].en", t), 64'(due_jump[t].en),
				64'(jump[t].en));
		assert property (@(negedge clk)
			due_on && due_jump[t].en |-> jump[t].addr == due_jump[t].addr)
			else stop_on_mismatch($sformatf("jump[%0d].addr", t), 64'(due_jump[t].addr),
				64'(jump[t].addr));
	end

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	// next cycle with lanes idle and no output expected unless set again
	task automatic tick();
		@(posedge clk);
		#2;
		for (int l = 0; l < `MT_NUM_LANES; l++) begin
			dispatch_sel[l] = core_pkg::TID_IDLE;
		end
		for (int t = 0; t < `MT_NUM_THREADS; t++) begin
			exp_wb[t]   = '0;
			exp_jump[t] = '0;
		end
	endtask

	task automatic present(input int t, input logic [31:0] pc, input logic [31:0] word,
		input logic [31:0] op1, input logic [31:0] op2);
		decode[t].valid = 1'b1;
		decode[t].pc    = pc;
		decode[t].ins   = word;
		decode[t].op1   = op1;
		decode[t].op2   = op2;
	endtask

	task automatic retire(input int t);
		decode[t].valid = 1'b0;
	endtask

	task automatic dispatch(input int lane, input int t);
		dispatch_sel[lane] = core_pkg::thread_id_t'(t);
	endtask

	task automatic expect_write(input int t, input logic [4:0] rd, input logic [31:0] data);
		exp_wb[t].wen  = 1'b1;
		exp_wb[t].rd   = rd;
		exp_wb[t].data = data;
	endtask

	task automatic expect_jump(input int t, input logic [31:0] addr);
		exp_jump[t].en   = 1'b1;
		exp_jump[t].addr = addr;
	endtask

	initial begin
		void'($urandom(32'h423b));
		rst  = 1'b0;
		for (int t = 0; t < `MT_NUM_THREADS; t++) begin
			decode[t]   = '0;
			exp_wb[t]   = '0;
			exp_jump[t] = '0;
		end
		for (int l = 0; l < `MT_NUM_LANES; l++) begin
			dispatch_sel[l] = core_pkg::TID_IDLE;
		end
		repeat (4) tick();
		rst = 1'b1;
		tick();

		// three lanes serving three threads through the bypass path
		a = $urandom();
		b = $urandom();
		c = $urandom();
		present(0, 32'h100, r_word(7'h00, 3'h0, 5'd1, 5'd2, 5'd3), a, b);
		present(1, 32'h200, r_word(7'h20, 3'h0, 5'd4, 5'd2, 5'd3), b, a);
		present(2, 32'h300, r_word(7'h00, 3'h4, 5'd6, 5'd2, 5'd3), a, c);
		dispatch(0, 0);
		dispatch(1, 1);
		dispatch(2, 2);
		expect_write(0, 5'd1, a + b);
		expect_write(1, 5'd4, b - a);
		expect_write(2, 5'd6, a ^ c);
		tick();
		retire(0);
		retire(1);
		retire(2);
		tick();

		// thread 1 fills its queue while pc repeats are dropped
		a = $urandom();
		b = $urandom();
		c = $urandom();
		present(1, 32'h1000, r_word(7'h00, 3'h0, 5'd7, 5'd10, 5'd11), a, b);
		tick();
		tick();
		present(1, 32'h1004, r_word(7'h00, 3'h6, 5'd8, 5'd10, 5'd11), c, a);
		tick();
		tick();
		present(1, 32'h1008, r_word(7'h00, 3'h7, 5'd9, 5'd10, 5'd11), b, c);
		tick();
		tick();
		present(1, 32'h1000, r_word(7'h00, 3'h0, 5'd7, 5'd10, 5'd11), a, b);
		tick();
		retire(1);
		dispatch(0, 1);
		expect_write(1, 5'd7, a + b);
		tick();
		dispatch(1, 1);
		expect_write(1, 5'd8, c | a);
		tick();
		dispatch(2, 1);
		expect_write(1, 5'd9, b & c);
		tick();
		dispatch(0, 1); // drained
		tick();

		// taken beq on thread 2 with two wrong-path entries queued
		a = $urandom();
		b = $urandom();
		present(2, 32'h2000, b_word(13'h1ff0, 3'h0, 5'd16, 5'd17), a, a);
		tick();
		present(2, 32'h2004, r_word(7'h00, 3'h0, 5'd18, 5'd16, 5'd17), a, b);
		tick();
		present(2, 32'h2008, r_word(7'h00, 3'h0, 5'd18, 5'd16, 5'd17), b, b);
		dispatch(1, 2);
		expect_jump(2, 32'h2000 + 32'hffff_fff0);
		tick();
		retire(2); // flush happens this cycle
		tick();
		dispatch(2, 2);
		tick();
		dispatch(0, 2);
		tick();
		present(2, 32'h3000, b_word(13'h0040, 3'h0, 5'd16, 5'd17), a, ~a); // not taken
		dispatch(2, 2);
		tick();
		present(2, 32'h3004, r_word(7'h00, 3'h0, 5'd18, 5'd16, 5'd17), a, b);
		dispatch(0, 2);
		expect_write(2, 5'd18, a + b);
		tick();
		retire(2);
		tick();

		// x5 written while its reader waits in the queue
		a = $urandom();
		b = $urandom();
		c = $urandom();
		present(3, 32'h4000, r_word(7'h00, 3'h0, 5'd5, 5'd12, 5'd13), a, b);
		tick();
		present(3, 32'h4004, r_word(7'h00, 3'h4, 5'd14, 5'd5, 5'd13), c, b); // c is stale
		tick();
		retire(3);
		dispatch(1, 3);
		expect_write(3, 5'd5, a + b);
		tick();
		dispatch(2, 3);
		expect_write(3, 5'd14, (a + b) ^ b);
		tick();

		// only the middle lane busy
		a = $urandom();
		b = $urandom();
		present(0, 32'h5000, r_word(7'h00, 3'h7, 5'd20, 5'd21, 5'd22), a, b);
		dispatch(1, 0);
		expect_write(0, 5'd20, a & b);
		tick();
		retire(0);
		tick();
		tick();

		// add into x0 leaves wen low
		present(1, 32'h6000, r_word(7'h00, 3'h0, 5'd0, 5'd21, 5'd22), a, b);
		dispatch(0, 1);
		tick();
		retire(1);
		tick();

		$display("** PASS **");
		$finish;
	end

endmodule
